/* task_mapper.f */
mesh_pkg.sv
task_pkg.sv
mapper_if.sv
map_ctrl.sv
pe_selector.sv
pe_occupancy.sv
id_map_table.sv
task_mapper_top.sv
tb_task_mapper.sv

/* tb_task_mapper.sv */
// Testbench for the task mapper
// Stimulus table with hand-worked expected results, applied in a loop
// Value checker, per-entry report and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_task_mapper;

  // Hold long enough for fifteen back-to-back roots to fill the mesh
  localparam int HOLD_CYCLES  = 16;
  localparam int RESET_CYCLES = 5;

  typedef struct packed {
    task_pkg::task_op_t op;
    mesh_pkg::coord_t   row;
    mesh_pkg::coord_t   col;
    logic               app_end;
    logic [7:0]         gap;
    logic               fail;
    mesh_pkg::node_id_t src;
    mesh_pkg::node_id_t dest;
  } entry_t;

  logic               clk;
  logic               rst_b;
  logic               task_valid;
  logic               root_task;
  mesh_pkg::coord_t   row;
  mesh_pkg::coord_t   col;
  logic               app_end;
  logic               map_valid;
  logic               map_fail;
  mesh_pkg::node_id_t src_id;
  mesh_pkg::node_id_t dest_id;

  entry_t table_q[$];
  int     error_count;
  int     entries_passed;
  int     entries_failed;
  int     limit_cycles;

  task_mapper_top #(
    .HOLD_CYCLES (HOLD_CYCLES)
  ) dut (
    .clk        (clk),
    .rst_b      (rst_b),
    .task_valid (task_valid),
    .root_task  (root_task),
    .row        (row),
    .col        (col),
    .app_end    (app_end),
    .map_valid  (map_valid),
    .map_fail   (map_fail),
    .src_id     (src_id),
    .dest_id    (dest_id)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // #################### Helpers
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, expected);
      error_count++;
    end
  endtask

  task automatic drive_idle();
    task_valid = 1'b0;
    root_task  = 1'b0;
    row        = '0;
    col        = '0;
    app_end    = 1'b0;
  endtask

  task automatic add_entry(input task_pkg::task_op_t op, input int r, input int c,
                           input logic flush, input int gap, input logic fail,
                           input int src, input int dest);
    entry_t e;
    e.op      = op;
    e.row     = mesh_pkg::coord_t'(r);
    e.col     = mesh_pkg::coord_t'(c);
    e.app_end = flush;
    e.gap     = 8'(gap);
    e.fail    = fail;
    e.src     = mesh_pkg::node_id_t'(src);
    e.dest    = mesh_pkg::node_id_t'(dest);
    table_q.push_back(e);
  endtask

  // Drive on the falling edge, result is checked one cycle later
  task automatic apply_entry(input int idx, input entry_t e);
    int errs_before;
    errs_before = error_count;
    repeat (e.gap) @(negedge clk);
    task_valid = (e.op != task_pkg::OP_IDLE);
    root_task  = (e.op == task_pkg::OP_ROOT);
    row        = e.row;
    col        = e.col;
    app_end    = e.app_end;
    @(negedge clk);
    if (e.op == task_pkg::OP_IDLE) begin
      check_value("map_valid", map_valid, 32'd0);
    end else if (map_valid !== 1'b1) begin
      $display("entry %0d: no result strobe in the cycle after the request", idx);
      error_count++;
    end else begin
      check_value("map_fail", map_fail, e.fail);
      check_value("src_id", src_id, e.src);
      check_value("dest_id", dest_id, e.dest);
    end
    drive_idle();
    if (error_count == errs_before) begin
      entries_passed++;
      $display("entry %0d op %0d row %0d col %0d: pass", idx, e.op, e.row, e.col);
    end else begin
      entries_failed++;
      $display("entry %0d op %0d row %0d col %0d: fail", idx, e.op, e.row, e.col);
    end
  endtask

  // #################### Stimulus table
  task automatic build_table();
    // Root on empty mesh, then children from the last placed PE
    add_entry(task_pkg::OP_ROOT,  0, 1, 1'b0, 0, 1'b0, 19, 19);
    add_entry(task_pkg::OP_CHILD, 1, 0, 1'b0, 0, 1'b0, 11, 19);
    add_entry(task_pkg::OP_CHILD, 2, 2, 1'b0, 0, 1'b0,  3,  3);
    add_entry(task_pkg::OP_CHILD, 1, 2, 1'b0, 0, 1'b0,  2,  2);
    // Roots in order, then the first PE again after the hold time
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, HOLD_CYCLES + 2, 1'b0, 19, 19);
    add_entry(task_pkg::OP_ROOT,  0, 2, 1'b0, 0, 1'b0, 26, 26);
    add_entry(task_pkg::OP_ROOT,  0, 3, 1'b0, 0, 1'b0, 18, 18);
    add_entry(task_pkg::OP_ROOT,  1, 1, 1'b0, HOLD_CYCLES, 1'b0, 19, 19);
    // Flush alone, then a flush together with a child request
    add_entry(task_pkg::OP_IDLE,  0, 0, 1'b1, 0, 1'b0,  0,  0);
    add_entry(task_pkg::OP_CHILD, 2, 1, 1'b0, 0, 1'b0, 11, 11);
    add_entry(task_pkg::OP_CHILD, 1, 2, 1'b1, 0, 1'b0,  3, 11);
    add_entry(task_pkg::OP_CHILD, 2, 1, 1'b0, 0, 1'b0,  2,  2);
    // Fifteen roots fill the mesh, the sixteenth has nowhere to go
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, HOLD_CYCLES + 2, 1'b0, 19, 19);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 26, 26);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 18, 18);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 11, 11);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 25, 25);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 10, 10);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 17, 17);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0,  3,  3);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 24, 24);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0,  9,  9);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0,  2,  2);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0, 16, 16);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0,  1,  1);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0,  8,  8);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b0,  0,  0);
    add_entry(task_pkg::OP_ROOT,  0, 0, 1'b0, 0, 1'b1,  0,  0);
  endtask

  // #################### Main sequence
  initial begin
    error_count    = 0;
    entries_passed = 0;
    entries_failed = 0;
    limit_cycles   = 0;
    rst_b          = 1'b0;
    drive_idle();
    build_table();
    limit_cycles = RESET_CYCLES + 20;
    foreach (table_q[i]) begin
      limit_cycles += table_q[i].gap + 2;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_b = 1'b1;
    foreach (table_q[i]) begin
      apply_entry(i, table_q[i]);
    end
    $display("%0d entries: %0d passed, %0d failed, %0d mismatches",
             table_q.size(), entries_passed, entries_failed, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* task_mapper_top.sv */
// Task mapper top level
// Plain request and result ports, mapper interface and all instances
`timescale 1ns/1ps
`default_nettype none

module task_mapper_top #(
  parameter int HOLD_CYCLES = 10
) (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                task_valid,
  input  logic                root_task,
  input  mesh_pkg::coord_t    row,
  input  mesh_pkg::coord_t    col,
  input  logic                app_end,
  output logic                map_valid,
  output logic                map_fail,
  output mesh_pkg::node_id_t  src_id,
  output mesh_pkg::node_id_t  dest_id
);

  // Control to table
  logic               tbl_write;
  mesh_pkg::coord_t   tbl_row;
  mesh_pkg::coord_t   tbl_col;
  mesh_pkg::node_id_t tbl_id;
  mesh_pkg::node_id_t tbl_dest;
  logic               tbl_hit;

  mapper_if mif ();

  map_ctrl u_map_ctrl (
    .clk        (clk),
    .rst_b      (rst_b),
    .task_valid (task_valid),
    .root_task  (root_task),
    .row        (row),
    .col        (col),
    .app_end    (app_end),
    .map_valid  (map_valid),
    .map_fail   (map_fail),
    .src_id     (src_id),
    .dest_id    (dest_id),
    .mif        (mif.ctrl),
    .tbl_write  (tbl_write),
    .tbl_row    (tbl_row),
    .tbl_col    (tbl_col),
    .tbl_id     (tbl_id),
    .tbl_dest   (tbl_dest),
    .tbl_hit    (tbl_hit)
  );

  pe_selector u_pe_selector (
    .mif (mif.sel)
  );

  pe_occupancy #(
    .HOLD_CYCLES (HOLD_CYCLES)
  ) u_pe_occupancy (
    .clk   (clk),
    .rst_b (rst_b),
    .mif   (mif.occ)
  );

  id_map_table u_id_map_table (
    .clk     (clk),
    .rst_b   (rst_b),
    .app_end (app_end),
    .write   (tbl_write),
    .wr_row  (tbl_row),
    .wr_col  (tbl_col),
    .wr_id   (tbl_id),
    .dest_id (tbl_dest),
    .hit     (tbl_hit)
  );

endmodule

`default_nettype wire

/* id_map_table.sv */
// Task-graph to network ID table
// One ID and valid bit per cell, transposed read, flush at app end
`timescale 1ns/1ps
`default_nettype none

module id_map_table (
  input  logic               clk,
  input  logic               rst_b,
  input  logic               app_end,
  input  logic               write,
  input  mesh_pkg::coord_t   wr_row,
  input  mesh_pkg::coord_t   wr_col,
  input  mesh_pkg::node_id_t wr_id,
  output mesh_pkg::node_id_t dest_id,
  output logic               hit
);

  localparam int NUM_CELL = mesh_pkg::NUM_PE;

  mesh_pkg::node_id_t  id_mem [NUM_CELL];
  logic [NUM_CELL-1:0] cell_valid;
  logic [3:0]          wr_idx;
  logic [3:0]          rd_idx;

  // Cells are row-major, read swaps row and column
  assign wr_idx = {wr_row, wr_col};
  assign rd_idx = {wr_col, wr_row};

  always_ff @(posedge clk) begin
    if (write) begin
      id_mem[wr_idx] <= wr_id;
    end
  end

  // Flush wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_b || app_end) begin
      cell_valid <= '0;
    end else if (write) begin
      cell_valid[wr_idx] <= 1'b1;
    end
  end

  // Read sees the contents from before this cycle's write
  assign hit     = cell_valid[rd_idx];
  assign dest_id = id_mem[rd_idx];

endmodule

`default_nettype wire

/* pe_occupancy.sv */
// PE occupancy
// Busy matrix built from one hold counter per PE
// Counter loads on commit and counts down to release
`timescale 1ns/1ps
`default_nettype none

module pe_occupancy #(
  parameter int HOLD_CYCLES = 10
) (
  input logic   clk,
  input logic   rst_b,
  mapper_if.occ mif
);

  localparam int NUM_PE = mesh_pkg::NUM_PE;
  localparam int CNT_W  = $clog2(HOLD_CYCLES + 1);

  localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(HOLD_CYCLES);

  logic [CNT_W-1:0] hold_cnt [NUM_PE];

  // #################### Hold counters
  // Busy from the commit edge until HOLD_CYCLES edges later
  always_ff @(posedge clk) begin
    if (!rst_b) begin
      for (int i = 0; i < NUM_PE; i++) begin
        hold_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_PE; i++) begin
        if (mif.commit && mif.pick == mesh_pkg::pe_idx_t'(i)) begin
          hold_cnt[i] <= HOLD_LOAD;
        end else if (hold_cnt[i] != '0) begin
          hold_cnt[i] <= hold_cnt[i] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PE; i++) begin
      mif.busy[i] = (hold_cnt[i] != '0);
    end
  end

  // Selector must never hand out a PE that is still held
  a_no_double_book: assert property (
    @(posedge clk) disable iff (!rst_b)
    mif.commit |-> !mif.busy[mif.pick]
  );

endmodule

`default_nettype wire

/* pe_selector.sv */
// PE selector
// Manhattan cost per PE, idle neighbor count and placement choice
// Root uses the controller as base, child uses the last placed PE
`timescale 1ns/1ps
`default_nettype none

module pe_selector (
  mapper_if.sel mif
);

  localparam int NUM_PE = mesh_pkg::NUM_PE;

  logic [NUM_PE-1:0] excluded;
  logic [3:0]        idle_cnt [NUM_PE];

  function automatic logic [2:0] abs_diff(input mesh_pkg::coord_t x,
                                          input mesh_pkg::coord_t y);
    return (x > y) ? {1'b0, x - y} : {1'b0, y - x};
  endfunction

  function automatic logic [2:0] manhattan(input mesh_pkg::pe_idx_t a,
                                           input mesh_pkg::pe_idx_t b);
    logic [2:0] dr;
    logic [2:0] dc;
    dr = abs_diff(mesh_pkg::pe_row(a), mesh_pkg::pe_row(b));
    dc = abs_diff(mesh_pkg::pe_col(a), mesh_pkg::pe_col(b));
    return dr + dc;
  endfunction

  // Busy PEs and the controller corner can never be chosen
  always_comb begin
    for (int i = 0; i < NUM_PE; i++) begin
      excluded[i] = mif.busy[i] | (mesh_pkg::pe_idx_t'(i) == mesh_pkg::CTRL_PE);
    end
  end

  // #################### Idle neighbors
  // Other free PEs within distance 2
  always_comb begin
    for (int i = 0; i < NUM_PE; i++) begin
      idle_cnt[i] = '0;
      for (int j = 0; j < NUM_PE; j++) begin
        if (j != i && !excluded[j] &&
            manhattan(mesh_pkg::pe_idx_t'(i), mesh_pkg::pe_idx_t'(j)) <= 3'd2) begin
          idle_cnt[i] = idle_cnt[i] + 4'd1;
        end
      end
    end
  end

  // #################### Choice
  // Scan in index order and only take a strictly better PE,
  // so the lowest index wins a full tie
  always_comb begin
    mesh_pkg::pe_idx_t base;
    logic [2:0]        cost;
    logic [2:0]        best_cost;
    logic [3:0]        best_idle;
    logic              better;
    base      = (mif.op == task_pkg::OP_ROOT) ? mesh_pkg::CTRL_PE : mif.last_pe;
    best_cost = '1;
    best_idle = '0;
    mif.pick  = '0;
    mif.found = 1'b0;
    for (int i = 0; i < NUM_PE; i++) begin
      cost   = manhattan(mesh_pkg::pe_idx_t'(i), base);
      better = 1'b0;
      if (mif.op != task_pkg::OP_IDLE && !excluded[i]) begin
        if (!mif.found || cost < best_cost) begin
          better = 1'b1;
        end else if (mif.op == task_pkg::OP_ROOT && cost == best_cost &&
                     idle_cnt[i] > best_idle) begin
          better = 1'b1;
        end
      end
      if (better) begin
        best_cost = cost;
        best_idle = idle_cnt[i];
        mif.pick  = mesh_pkg::pe_idx_t'(i);
        mif.found = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* map_ctrl.sv */
// Mapper control
// Request decode, commit strobe, last placed PE and registered results
`timescale 1ns/1ps
`default_nettype none

module map_ctrl (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                task_valid,
  input  logic                root_task,
  input  mesh_pkg::coord_t    row,
  input  mesh_pkg::coord_t    col,
  input  logic                app_end,
  output logic                map_valid,
  output logic                map_fail,
  output mesh_pkg::node_id_t  src_id,
  output mesh_pkg::node_id_t  dest_id,
  mapper_if.ctrl              mif,
  output logic                tbl_write,
  output mesh_pkg::coord_t    tbl_row,
  output mesh_pkg::coord_t    tbl_col,
  output mesh_pkg::node_id_t  tbl_id,
  input  mesh_pkg::node_id_t  tbl_dest,
  input  logic                tbl_hit
);

  mesh_pkg::node_id_t pick_id;
  mesh_pkg::node_id_t next_dest;

  // #################### Request decode
  always_comb begin
    if (!task_valid) begin
      mif.op = task_pkg::OP_IDLE;
    end else if (root_task) begin
      mif.op = task_pkg::OP_ROOT;
    end else begin
      mif.op = task_pkg::OP_CHILD;
    end
  end

  assign mif.commit = task_valid & mif.found;
  assign pick_id    = mesh_pkg::pe_node_id(mif.pick);

  // Flush at application end takes priority over the write
  assign tbl_write = mif.commit & ~app_end;
  assign tbl_row   = row;
  assign tbl_col   = col;
  assign tbl_id    = pick_id;

  // Child takes the transposed cell if it was written, else itself
  assign next_dest = (root_task || !tbl_hit) ? pick_id : tbl_dest;

  // #################### Result registers
  always_ff @(posedge clk) begin
    if (!rst_b) begin
      map_valid   <= 1'b0;
      map_fail    <= 1'b0;
      mif.last_pe <= mesh_pkg::CTRL_PE;
    end else begin
      map_valid <= task_valid;
      map_fail  <= task_valid & ~mif.found;
      if (mif.commit) begin
        mif.last_pe <= mif.pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (task_valid) begin
      src_id  <= mif.found ? pick_id : '0;
      dest_id <= mif.found ? next_dest : '0;
    end
  end

  // A commit only on a found PE, never on the controller corner
  a_commit_found: assert property (
    @(posedge clk) disable iff (!rst_b)
    mif.commit |-> mif.found && (mif.pick != mesh_pkg::CTRL_PE)
  );

endmodule

`default_nettype wire

/* mapper_if.sv */
// Mapper interface between control and datapath
// Occupancy, placement choice and commit strobe
`timescale 1ns/1ps
`default_nettype none

interface mapper_if;

  // Occupancy from the busy matrix
  mesh_pkg::busy_vec_t busy;

  // Request decode and placement history from control
  task_pkg::task_op_t  op;
  mesh_pkg::pe_idx_t   last_pe;
  logic                commit;

  // Selector result
  mesh_pkg::pe_idx_t   pick;
  logic                found;

  modport ctrl (
    input  busy, pick, found,
    output op, last_pe, commit
  );

  modport sel (
    input  busy, op, last_pe,
    output pick, found
  );

  modport occ (
    input  commit, pick,
    output busy
  );

endinterface

`default_nettype wire

/* task_pkg.sv */
// Task request encoding
// Operation enum shared by the control path and the testbench
`default_nettype none

package task_pkg;

  // OP_IDLE when no request is strobed this cycle
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_ROOT  = 2'd1,
    OP_CHILD = 2'd2
  } task_op_t;

endpackage

`default_nettype wire

/* mesh_pkg.sv */
// Mesh geometry for the 4x4 PE array
// PE index, coordinate, network ID and busy vector types
// Controller position and index to coordinate helpers
`default_nettype none

package mesh_pkg;

  localparam int MESH_DIM = 4;
  localparam int NUM_PE   = MESH_DIM * MESH_DIM;

  // Task controller owns this corner of the mesh
  localparam int CTRL_ROW = 3;
  localparam int CTRL_COL = 3;

  typedef logic [3:0]        pe_idx_t;
  typedef logic [1:0]        coord_t;
  typedef logic [4:0]        node_id_t;
  typedef logic [NUM_PE-1:0] busy_vec_t;

  localparam pe_idx_t CTRL_PE = pe_idx_t'(CTRL_ROW * MESH_DIM + CTRL_COL);

  // Row-major index, row in the upper bits
  function automatic coord_t pe_row(input pe_idx_t idx);
    return idx[3:2];
  endfunction

  function automatic coord_t pe_col(input pe_idx_t idx);
    return idx[1:0];
  endfunction

  // Network ID is row * 8 + col
  function automatic node_id_t pe_node_id(input pe_idx_t idx);
    return {pe_row(idx), 1'b0, pe_col(idx)};
  endfunction

endpackage

`default_nettype wire
